/* rtl/mem_map_pkg.sv */
package mem_map_pkg;

   localparam int ADDR_WIDTH  = 16;
   localparam int DATA_WIDTH  = 8;
   localparam int NUM_REGIONS = 4;

   // One-hot select bit positions
   localparam int REGION_IOREG     = 0;
   localparam int REGION_CARTRIDGE = 1;
   localparam int REGION_LCDRAM    = 2;
   localparam int REGION_WRAM      = 3;

   // Low bound inclusive, high bound exclusive
   localparam logic [ADDR_WIDTH-1:0] CARTRIDGE_LO     = 16'h0000;
   localparam logic [ADDR_WIDTH-1:0] CARTRIDGE_HI     = 16'h8000;
   localparam logic [ADDR_WIDTH-1:0] EXT_EXPANSION_LO = 16'hA000;
   localparam logic [ADDR_WIDTH-1:0] EXT_EXPANSION_HI = 16'hC000;
   localparam logic [ADDR_WIDTH-1:0] LCDRAM_LO        = 16'h8000;
   localparam logic [ADDR_WIDTH-1:0] LCDRAM_HI        = 16'hA000;
   localparam logic [ADDR_WIDTH-1:0] WRAM_LO          = 16'hC000;
   localparam logic [ADDR_WIDTH-1:0] WRAM_HI          = 16'hE000;
   localparam logic [ADDR_WIDTH-1:0] OAM_LO           = 16'hFE00;
   localparam logic [ADDR_WIDTH-1:0] OAM_HI           = 16'hFEA0;
   localparam logic [ADDR_WIDTH-1:0] IOREG_LO         = 16'hFF00;
   localparam logic [ADDR_WIDTH-1:0] IOREG_HI         = 16'hFF80;

   localparam logic [7:0] REG_PAGE = 8'hFF;   // LCD registers live here

   localparam logic [7:0] LCDC_OFFSET = 8'h40;
   localparam logic [7:0] STAT_OFFSET = 8'h41;
   localparam logic [7:0] SCY_OFFSET  = 8'h42;
   localparam logic [7:0] SCX_OFFSET  = 8'h43;
   localparam logic [7:0] LY_OFFSET   = 8'h44;
   localparam logic [7:0] LYC_OFFSET  = 8'h45;
   localparam logic [7:0] BGP_OFFSET  = 8'h47;
   localparam logic [7:0] OBP0_OFFSET = 8'h48;
   localparam logic [7:0] OBP1_OFFSET = 8'h49;
   localparam logic [7:0] WY_OFFSET   = 8'h4A;
   localparam logic [7:0] WX_OFFSET   = 8'h4B;
   localparam logic [7:0] VBK_OFFSET  = 8'h4F;
   localparam logic [7:0] BCPS_OFFSET = 8'h68;
   localparam logic [7:0] BCPD_OFFSET = 8'h69;
   localparam logic [7:0] OCPS_OFFSET = 8'h6A;
   localparam logic [7:0] OCPD_OFFSET = 8'h6B;

   localparam int NUM_LCD_REGS = 16;

   localparam logic [NUM_LCD_REGS-1:0][7:0] LCD_REG_OFFSETS = {
      LCDC_OFFSET, STAT_OFFSET, SCY_OFFSET,  SCX_OFFSET,
      LY_OFFSET,   LYC_OFFSET,  BGP_OFFSET,  OBP0_OFFSET,
      OBP1_OFFSET, WY_OFFSET,   WX_OFFSET,   VBK_OFFSET,
      BCPS_OFFSET, BCPD_OFFSET, OCPS_OFFSET, OCPD_OFFSET
   };

   typedef struct packed {
      logic [7:0] page;
      logic [7:0] offset;
   } page_addr_t;

   // Flat view for range compares, paged view for register matches
   typedef union packed {
      logic [ADDR_WIDTH-1:0] full;
      page_addr_t            paged;
   } mem_addr_t;

endpackage

/* rtl/region_decoder.sv */
module region_decoder (
   input  mem_map_pkg::mem_addr_t                addr,
   input  logic                                  we_l,
   input  logic                                  re_l,
   output logic [mem_map_pkg::NUM_REGIONS-1:0]   region
);

   import mem_map_pkg::*;

   logic active;
   logic in_cart;
   logic in_ext;
   logic in_vram;
   logic in_oam;
   logic in_wram;
   logic in_ioreg;
   logic lcd_reg_hit;

   function automatic logic in_range(input logic [ADDR_WIDTH-1:0] a,
                                     input logic [ADDR_WIDTH-1:0] lo,
                                     input logic [ADDR_WIDTH-1:0] hi);
      return (a >= lo) && (a < hi);
   endfunction

   assign active = ~we_l | ~re_l;   // Either strobe low

   assign in_cart  = in_range(addr.full, CARTRIDGE_LO, CARTRIDGE_HI);
   assign in_ext   = in_range(addr.full, EXT_EXPANSION_LO, EXT_EXPANSION_HI);
   assign in_vram  = in_range(addr.full, LCDRAM_LO, LCDRAM_HI);
   assign in_oam   = in_range(addr.full, OAM_LO, OAM_HI);
   assign in_wram  = in_range(addr.full, WRAM_LO, WRAM_HI);
   assign in_ioreg = in_range(addr.full, IOREG_LO, IOREG_HI);

   always_comb begin
      lcd_reg_hit = 1'b0;
      if (addr.paged.page == REG_PAGE) begin
         for (int i = 0; i < NUM_LCD_REGS; i++) begin
            if (addr.paged.offset == LCD_REG_OFFSETS[i]) begin
               lcd_reg_hit = 1'b1;
            end
         end
      end
   end

   always_comb begin
      region = '0;
      if (active) begin
         region[REGION_CARTRIDGE] = in_cart | in_ext;
         region[REGION_LCDRAM]    = in_vram | in_oam | lcd_reg_hit;
         region[REGION_IOREG]     = in_ioreg & ~lcd_reg_hit;   // LCD regs carved out
         region[REGION_WRAM]      = in_wram;
      end
      // Map bounds and the register carve-out must never overlap
      assert ($onehot0(region))
         else $error("region_decoder: overlapping regions %b for %h", region, addr.full);
   end

endmodule

/* rtl/slave_port_mux.sv */
module slave_port_mux #(
   parameter int DATA_WIDTH = 8
) (
   input  logic                                 clk,
   input  logic                                 reset,

   input  logic                                 cpu_sel,
   input  logic                                 wdma_sel,
   input  logic                                 rdma_sel,

   input  logic [mem_map_pkg::ADDR_WIDTH-1:0]   cpu_addr,
   input  logic [mem_map_pkg::ADDR_WIDTH-1:0]   wdma_addr,
   input  logic [mem_map_pkg::ADDR_WIDTH-1:0]   rdma_addr,

   input  logic                                 cpu_we_l,
   input  logic                                 cpu_re_l,
   input  logic                                 wdma_we_l,
   input  logic                                 rdma_re_l,

   input  logic [DATA_WIDTH-1:0]                cpu_wdata,
   input  logic [DATA_WIDTH-1:0]                wdma_wdata,

   output logic [mem_map_pkg::ADDR_WIDTH-1:0]   addr,
   output logic [DATA_WIDTH-1:0]                wdata,
   output logic                                 we_l,
   output logic                                 re_l
);

   logic cpu_grant;
   logic wdma_grant;
   logic rdma_grant;

   // Fixed priority, CPU then DMA write then DMA read
   assign cpu_grant  = cpu_sel;
   assign wdma_grant = wdma_sel & ~cpu_sel;
   assign rdma_grant = rdma_sel & ~cpu_sel & ~wdma_sel;

   always_comb begin
      addr  = '0;
      wdata = '0;
      we_l  = 1'b1;
      re_l  = 1'b1;
      if (cpu_grant) begin
         addr  = cpu_addr;
         wdata = cpu_wdata;
         we_l  = cpu_we_l;
         re_l  = cpu_re_l;
      end
      if (wdma_grant) begin
         addr  = wdma_addr;
         wdata = wdma_wdata;
         we_l  = wdma_we_l;   // Read strobe stays high
      end
      if (rdma_grant) begin
         addr = rdma_addr;
         re_l = rdma_re_l;    // Write strobe and data stay idle
      end
   end

   // A slave never sees a read and a write at once
   slave_strobe_exclusive: assert property (
      @(posedge clk) disable iff (reset)
      !(!we_l && !re_l)
   ) else $error("slave_port_mux: we_l and re_l both low at %h", addr);

   // Idle port carries no stale address or data
   slave_idle_quiet: assert property (
      @(posedge clk) disable iff (reset)
      (we_l && re_l) |-> (addr == '0 && wdata == '0)
   ) else $error("slave_port_mux: idle port drives addr %h wdata %h", addr, wdata);

endmodule

/* rtl/read_return_mux.sv */
module read_return_mux #(
   parameter int DATA_WIDTH = 8
) (
   input  logic [mem_map_pkg::NUM_REGIONS-1:0]  region,
   input  logic                                 re_l,

   input  logic [DATA_WIDTH-1:0]                ioreg_rdata,
   input  logic [DATA_WIDTH-1:0]                cartridge_rdata,
   input  logic [DATA_WIDTH-1:0]                lcdram_rdata,
   input  logic [DATA_WIDTH-1:0]                wram_rdata,

   output logic [DATA_WIDTH-1:0]                rdata,
   output logic                                 rdata_valid
);

   import mem_map_pkg::*;

   logic                  reading;
   logic [DATA_WIDTH-1:0] ioreg_mask;
   logic [DATA_WIDTH-1:0] cart_mask;
   logic [DATA_WIDTH-1:0] lcdram_mask;
   logic [DATA_WIDTH-1:0] wram_mask;

   assign reading = ~re_l;

   // Region is one-hot, so an AND-OR mux is enough
   assign ioreg_mask  = {DATA_WIDTH{reading & region[REGION_IOREG]}};
   assign cart_mask   = {DATA_WIDTH{reading & region[REGION_CARTRIDGE]}};
   assign lcdram_mask = {DATA_WIDTH{reading & region[REGION_LCDRAM]}};
   assign wram_mask   = {DATA_WIDTH{reading & region[REGION_WRAM]}};

   assign rdata = (ioreg_mask  & ioreg_rdata)
                | (cart_mask   & cartridge_rdata)
                | (lcdram_mask & lcdram_rdata)
                | (wram_mask   & wram_rdata);

   assign rdata_valid = reading & (|region);   // Unmapped reads stay invalid

endmodule

/* rtl/memory_router.sv */
module memory_router #(
   parameter int DATA_WIDTH = mem_map_pkg::DATA_WIDTH
) (
   input  logic                                 clk,
   input  logic                                 reset,

   // CPU master
   input  logic [mem_map_pkg::ADDR_WIDTH-1:0]   cpu_addr,
   input  logic [DATA_WIDTH-1:0]                cpu_wdata,
   input  logic                                 cpu_we_l,
   input  logic                                 cpu_re_l,
   output logic [DATA_WIDTH-1:0]                cpu_rdata,
   output logic                                 cpu_rdata_valid,

   // DMA read port
   input  logic [mem_map_pkg::ADDR_WIDTH-1:0]   rdma_addr,
   input  logic                                 rdma_re_l,
   output logic [DATA_WIDTH-1:0]                rdma_rdata,

   // DMA write port
   input  logic [mem_map_pkg::ADDR_WIDTH-1:0]   wdma_addr,
   input  logic [DATA_WIDTH-1:0]                wdma_wdata,
   input  logic                                 wdma_we_l,

   // I/O registers
   output logic [mem_map_pkg::ADDR_WIDTH-1:0]   ioreg_addr,
   output logic [DATA_WIDTH-1:0]                ioreg_wdata,
   output logic                                 ioreg_we_l,
   output logic                                 ioreg_re_l,
   input  logic [DATA_WIDTH-1:0]                ioreg_rdata,

   // Cartridge and external expansion
   output logic [mem_map_pkg::ADDR_WIDTH-1:0]   cartridge_addr,
   output logic [DATA_WIDTH-1:0]                cartridge_wdata,
   output logic                                 cartridge_we_l,
   output logic                                 cartridge_re_l,
   input  logic [DATA_WIDTH-1:0]                cartridge_rdata,

   // Video RAM, OAM and LCD registers
   output logic [mem_map_pkg::ADDR_WIDTH-1:0]   lcdram_addr,
   output logic [DATA_WIDTH-1:0]                lcdram_wdata,
   output logic                                 lcdram_we_l,
   output logic                                 lcdram_re_l,
   input  logic [DATA_WIDTH-1:0]                lcdram_rdata,

   // Working RAM
   output logic [mem_map_pkg::ADDR_WIDTH-1:0]   wram_addr,
   output logic [DATA_WIDTH-1:0]                wram_wdata,
   output logic                                 wram_we_l,
   output logic                                 wram_re_l,
   input  logic [DATA_WIDTH-1:0]                wram_rdata
);

   import mem_map_pkg::*;

   logic [NUM_REGIONS-1:0] cpu_region;
   logic [NUM_REGIONS-1:0] rdma_region;
   logic [NUM_REGIONS-1:0] wdma_region;

   region_decoder u_cpu_dec (
      .addr   (cpu_addr),
      .we_l   (cpu_we_l),
      .re_l   (cpu_re_l),
      .region (cpu_region)
   );

   region_decoder u_rdma_dec (
      .addr   (rdma_addr),
      .we_l   (1'b1),        // Read-only master
      .re_l   (rdma_re_l),
      .region (rdma_region)
   );

   region_decoder u_wdma_dec (
      .addr   (wdma_addr),
      .we_l   (wdma_we_l),
      .re_l   (1'b1),        // Write-only master
      .region (wdma_region)
   );

   slave_port_mux #(.DATA_WIDTH(DATA_WIDTH)) u_ioreg_port (
      .clk        (clk),
      .reset      (reset),
      .cpu_sel    (cpu_region[REGION_IOREG]),
      .wdma_sel   (wdma_region[REGION_IOREG]),
      .rdma_sel   (rdma_region[REGION_IOREG]),
      .cpu_addr   (cpu_addr),
      .wdma_addr  (wdma_addr),
      .rdma_addr  (rdma_addr),
      .cpu_we_l   (cpu_we_l),
      .cpu_re_l   (cpu_re_l),
      .wdma_we_l  (wdma_we_l),
      .rdma_re_l  (rdma_re_l),
      .cpu_wdata  (cpu_wdata),
      .wdma_wdata (wdma_wdata),
      .addr       (ioreg_addr),
      .wdata      (ioreg_wdata),
      .we_l       (ioreg_we_l),
      .re_l       (ioreg_re_l)
   );

   slave_port_mux #(.DATA_WIDTH(DATA_WIDTH)) u_cart_port (
      .clk        (clk),
      .reset      (reset),
      .cpu_sel    (cpu_region[REGION_CARTRIDGE]),
      .wdma_sel   (wdma_region[REGION_CARTRIDGE]),
      .rdma_sel   (rdma_region[REGION_CARTRIDGE]),
      .cpu_addr   (cpu_addr),
      .wdma_addr  (wdma_addr),
      .rdma_addr  (rdma_addr),
      .cpu_we_l   (cpu_we_l),
      .cpu_re_l   (cpu_re_l),
      .wdma_we_l  (wdma_we_l),
      .rdma_re_l  (rdma_re_l),
      .cpu_wdata  (cpu_wdata),
      .wdma_wdata (wdma_wdata),
      .addr       (cartridge_addr),
      .wdata      (cartridge_wdata),
      .we_l       (cartridge_we_l),
      .re_l       (cartridge_re_l)
   );

   slave_port_mux #(.DATA_WIDTH(DATA_WIDTH)) u_lcdram_port (
      .clk        (clk),
      .reset      (reset),
      .cpu_sel    (cpu_region[REGION_LCDRAM]),
      .wdma_sel   (wdma_region[REGION_LCDRAM]),
      .rdma_sel   (rdma_region[REGION_LCDRAM]),
      .cpu_addr   (cpu_addr),
      .wdma_addr  (wdma_addr),
      .rdma_addr  (rdma_addr),
      .cpu_we_l   (cpu_we_l),
      .cpu_re_l   (cpu_re_l),
      .wdma_we_l  (wdma_we_l),
      .rdma_re_l  (rdma_re_l),
      .cpu_wdata  (cpu_wdata),
      .wdma_wdata (wdma_wdata),
      .addr       (lcdram_addr),
      .wdata      (lcdram_wdata),
      .we_l       (lcdram_we_l),
      .re_l       (lcdram_re_l)
   );

   slave_port_mux #(.DATA_WIDTH(DATA_WIDTH)) u_wram_port (
      .clk        (clk),
      .reset      (reset),
      .cpu_sel    (cpu_region[REGION_WRAM]),
      .wdma_sel   (wdma_region[REGION_WRAM]),
      .rdma_sel   (rdma_region[REGION_WRAM]),
      .cpu_addr   (cpu_addr),
      .wdma_addr  (wdma_addr),
      .rdma_addr  (rdma_addr),
      .cpu_we_l   (cpu_we_l),
      .cpu_re_l   (cpu_re_l),
      .wdma_we_l  (wdma_we_l),
      .rdma_re_l  (rdma_re_l),
      .cpu_wdata  (cpu_wdata),
      .wdma_wdata (wdma_wdata),
      .addr       (wram_addr),
      .wdata      (wram_wdata),
      .we_l       (wram_we_l),
      .re_l       (wram_re_l)
   );

   read_return_mux #(.DATA_WIDTH(DATA_WIDTH)) u_cpu_ret (
      .region          (cpu_region),
      .re_l            (cpu_re_l),
      .ioreg_rdata     (ioreg_rdata),
      .cartridge_rdata (cartridge_rdata),
      .lcdram_rdata    (lcdram_rdata),
      .wram_rdata      (wram_rdata),
      .rdata           (cpu_rdata),
      .rdata_valid     (cpu_rdata_valid)
   );

   read_return_mux #(.DATA_WIDTH(DATA_WIDTH)) u_rdma_ret (
      .region          (rdma_region),
      .re_l            (rdma_re_l),
      .ioreg_rdata     (ioreg_rdata),
      .cartridge_rdata (cartridge_rdata),
      .lcdram_rdata    (lcdram_rdata),
      .wram_rdata      (wram_rdata),
      .rdata           (rdma_rdata),
      .rdata_valid     ()
   );

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen (
   output logic clk,
   output logic reset
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);          // Release away from the sampling edge
      reset = 1'b0;
   end

endmodule

/* verif/tb_memory_router.sv */
module tb_memory_router;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int SLOT_IO   = 0;
   localparam int SLOT_CART = 1;
   localparam int SLOT_LCD  = 2;
   localparam int SLOT_WRAM = 3;
   localparam int SLOT_NONE = -1;

   // Per-test cycles, each including its closing idle cycle
   localparam int TEST_CYCLES = 6 + 65 + 41 + 13 + 33 + 17;
   localparam int CYCLE_LIMIT = TEST_CYCLES + 20;

   localparam logic [3:0][7:0] SLAVE_KEY = {8'hC3, 8'h96, 8'h3C, 8'h5A};

   logic        clk, reset;
   logic [15:0] cpu_addr, rdma_addr, wdma_addr;
   logic [7:0]  cpu_wdata, wdma_wdata, cpu_rdata, rdma_rdata;
   logic        cpu_we_l, cpu_re_l, rdma_re_l, wdma_we_l, cpu_rdata_valid;
   logic [15:0] ioreg_addr, cartridge_addr, lcdram_addr, wram_addr;
   logic [7:0]  ioreg_wdata, cartridge_wdata, lcdram_wdata, wram_wdata;
   logic [7:0]  ioreg_rdata, cartridge_rdata, lcdram_rdata, wram_rdata;
   logic        ioreg_we_l, cartridge_we_l, lcdram_we_l, wram_we_l;
   logic        ioreg_re_l, cartridge_re_l, lcdram_re_l, wram_re_l;

   logic [15:0] act_addr [4];
   logic [7:0]  act_wdata [4];
   logic        act_we_l [4];
   logic        act_re_l [4];
   logic [15:0] exp_addr [4];
   logic [7:0]  exp_wdata [4];
   logic        exp_we_l [4];
   logic        exp_re_l [4];
   logic [7:0]  exp_cpu_rdata, exp_rdma_rdata;
   logic        exp_cpu_valid;
   int          cpu_r, rdma_r, wdma_r;

   logic [31:0] lcg_state = 32'd60318;
   int          fail_count = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          test_start_fails;
   int          cycle_count = 0;
   string       test_name;

   logic [7:0] lcd_offsets [16] = '{8'h40, 8'h41, 8'h42, 8'h43, 8'h44, 8'h45, 8'h47, 8'h48,
                                    8'h49, 8'h4A, 8'h4B, 8'h4F, 8'h68, 8'h69, 8'h6A, 8'h6B};

   tb_clock_gen u_clock (.clk(clk), .reset(reset));

   memory_router DUT (.*);

   // Slave models answer with the low address byte scrambled per slave
   assign ioreg_rdata     = ioreg_addr[7:0] ^ SLAVE_KEY[SLOT_IO];
   assign cartridge_rdata = cartridge_addr[7:0] ^ SLAVE_KEY[SLOT_CART];
   assign lcdram_rdata    = lcdram_addr[7:0] ^ SLAVE_KEY[SLOT_LCD];
   assign wram_rdata      = wram_addr[7:0] ^ SLAVE_KEY[SLOT_WRAM];

   assign act_addr  = '{ioreg_addr, cartridge_addr, lcdram_addr, wram_addr};
   assign act_wdata = '{ioreg_wdata, cartridge_wdata, lcdram_wdata, wram_wdata};
   assign act_we_l  = '{ioreg_we_l, cartridge_we_l, lcdram_we_l, wram_we_l};
   assign act_re_l  = '{ioreg_re_l, cartridge_re_l, lcdram_re_l, wram_re_l};

   function automatic logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[31:16];
   endfunction

   function automatic logic is_lcd_reg(input logic [7:0] o);
      return (o >= 8'h40 && o <= 8'h45) || (o >= 8'h47 && o <= 8'h4B) ||
             (o == 8'h4F) || (o >= 8'h68 && o <= 8'h6B);
   endfunction

   function automatic int map_region(input logic [15:0] a);
      if (a < 16'h8000) return SLOT_CART;
      if (a < 16'hA000) return SLOT_LCD;
      if (a < 16'hC000) return SLOT_CART;   // External expansion
      if (a < 16'hE000) return SLOT_WRAM;
      if (a >= 16'hFE00 && a < 16'hFEA0) return SLOT_LCD;
      if (a[15:8] == 8'hFF && is_lcd_reg(a[7:0])) return SLOT_LCD;
      if (a >= 16'hFF00 && a < 16'hFF80) return SLOT_IO;
      return SLOT_NONE;
   endfunction

   function automatic logic [15:0] pick_addr(input int s, input logic [15:0] r);
      case (s)
         SLOT_IO:   return 16'hFF00 | {10'h000, r[5:0]};   // Below the LCD registers
         SLOT_CART: return {1'b0, r[14:0]};
         SLOT_LCD:  return {3'b100, r[12:0]};
         default:   return {3'b110, r[12:0]};
      endcase
   endfunction

   function automatic string slave_label(input int s);
      case (s)
         SLOT_IO:   return "ioreg";
         SLOT_CART: return "cartridge";
         SLOT_LCD:  return "lcdram";
         default:   return "wram";
      endcase
   endfunction

   // Reference model of routing, priority and read return
   always_comb begin
      cpu_r  = map_region(cpu_addr);
      rdma_r = map_region(rdma_addr);
      wdma_r = map_region(wdma_addr);
      for (int s = 0; s < 4; s++) begin
         exp_addr[s]  = 16'h0000;
         exp_wdata[s] = 8'h00;
         exp_we_l[s]  = 1'b1;
         exp_re_l[s]  = 1'b1;
         if ((!cpu_we_l || !cpu_re_l) && cpu_r == s) begin
            exp_addr[s]  = cpu_addr;
            exp_wdata[s] = cpu_wdata;
            exp_we_l[s]  = cpu_we_l;
            exp_re_l[s]  = cpu_re_l;
         end else if (!wdma_we_l && wdma_r == s) begin
            exp_addr[s]  = wdma_addr;
            exp_wdata[s] = wdma_wdata;
            exp_we_l[s]  = 1'b0;
         end else if (!rdma_re_l && rdma_r == s) begin
            exp_addr[s] = rdma_addr;
            exp_re_l[s] = 1'b0;
         end
      end
      exp_cpu_rdata  = 8'h00;
      exp_cpu_valid  = 1'b0;
      exp_rdma_rdata = 8'h00;
      if (!cpu_re_l && cpu_r != SLOT_NONE) begin
         exp_cpu_rdata = exp_addr[cpu_r[1:0]][7:0] ^ SLAVE_KEY[cpu_r[1:0]];
         exp_cpu_valid = 1'b1;
      end
      if (!rdma_re_l && rdma_r != SLOT_NONE) begin
         exp_rdma_rdata = exp_addr[rdma_r[1:0]][7:0] ^ SLAVE_KEY[rdma_r[1:0]];
      end
   end

   task automatic report_mismatch(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
      fail_count++;
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
   endtask

   for (genvar s = 0; s < 4; s++) begin : g_slave_check
      addr_match: assert property (@(posedge clk) act_addr[s] == exp_addr[s])
         else report_mismatch({slave_label(s), "_addr"}, exp_addr[s], act_addr[s]);
      wdata_match: assert property (@(posedge clk) act_wdata[s] == exp_wdata[s])
         else report_mismatch({slave_label(s), "_wdata"}, {8'h00, exp_wdata[s]},
                              {8'h00, act_wdata[s]});
      we_match: assert property (@(posedge clk) act_we_l[s] == exp_we_l[s])
         else report_mismatch({slave_label(s), "_we_l"}, {15'h0, exp_we_l[s]},
                              {15'h0, act_we_l[s]});
      re_match: assert property (@(posedge clk) act_re_l[s] == exp_re_l[s])
         else report_mismatch({slave_label(s), "_re_l"}, {15'h0, exp_re_l[s]},
                              {15'h0, act_re_l[s]});
   end

   cpu_rdata_match: assert property (@(posedge clk) cpu_rdata == exp_cpu_rdata)
      else report_mismatch("cpu_rdata", {8'h00, exp_cpu_rdata}, {8'h00, cpu_rdata});
   cpu_valid_match: assert property (@(posedge clk) cpu_rdata_valid == exp_cpu_valid)
      else report_mismatch("cpu_rdata_valid", {15'h0, exp_cpu_valid}, {15'h0, cpu_rdata_valid});
   rdma_rdata_match: assert property (@(posedge clk) rdma_rdata == exp_rdma_rdata)
      else report_mismatch("rdma_rdata", {8'h00, exp_rdma_rdata}, {8'h00, rdma_rdata});

   task automatic apply_inputs(input logic [15:0] c_addr, input logic [7:0] c_data,
                               input logic c_we_l, input logic c_re_l,
                               input logic [15:0] r_addr, input logic r_re_l,
                               input logic [15:0] w_addr, input logic [7:0] w_data,
                               input logic w_we_l);
      @(negedge clk);
      cpu_addr   = c_addr;
      cpu_wdata  = c_data;
      cpu_we_l   = c_we_l;
      cpu_re_l   = c_re_l;
      rdma_addr  = r_addr;
      rdma_re_l  = r_re_l;
      wdma_addr  = w_addr;
      wdma_wdata = w_data;
      wdma_we_l  = w_we_l;
   endtask

   task automatic start_test(input string name);
      test_name        = name;
      test_start_fails = fail_count;
   endtask

   task automatic finish_test();
      apply_inputs(16'h0, 8'h0, 1'b1, 1'b1, 16'h0, 1'b1, 16'h0, 8'h0, 1'b1);
      if (fail_count == test_start_fails) begin
         tests_passed++;
         $display("%s: pass", test_name);
      end else begin
         tests_failed++;
         $display("%s: %0d mismatches", test_name, fail_count - test_start_fails);
      end
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      logic [15:0] r;
      logic [15:0] d;
      logic [15:0] base;
      cpu_addr   = 16'h0;
      cpu_wdata  = 8'h0;
      cpu_we_l   = 1'b1;
      cpu_re_l   = 1'b1;
      rdma_addr  = 16'h0;
      rdma_re_l  = 1'b1;
      wdma_addr  = 16'h0;
      wdma_wdata = 8'h0;
      wdma_we_l  = 1'b1;

      start_test("idle");                  // Spans the reset window
      repeat (5) @(negedge clk);
      finish_test();

      start_test("decode");
      for (int i = 0; i < 64; i++) begin
         r = lcg_next();
         d = lcg_next();
         apply_inputs(r, d[7:0], d[8], ~d[8], 16'h0, 1'b1, 16'h0, 8'h0, 1'b1);
      end
      finish_test();

      start_test("lcd_registers");
      for (int i = 0; i < 16; i++) begin
         apply_inputs({8'hFF, lcd_offsets[i[3:0]]}, 8'h00, 1'b1, 1'b0,
                      16'h0, 1'b1, 16'h0, 8'h0, 1'b1);
         apply_inputs({8'hFF, lcd_offsets[i[3:0]]}, 8'hE7, 1'b0, 1'b1,
                      16'h0, 1'b1, 16'h0, 8'h0, 1'b1);
      end
      for (int i = 0; i < 8; i++) begin    // Echo RAM, gap and high RAM
         if (i < 4) begin
            r = 16'hE000 + 16'(i) * 16'h0711;
         end else if (i < 6) begin
            r = 16'hFEA0 + 16'(i) * 16'h0011;
         end else begin
            r = 16'hFF80 + 16'(i) * 16'h0011;
         end
         apply_inputs(r, 8'h00, 1'b1, 1'b0, 16'h0, 1'b1, 16'h0, 8'h0, 1'b1);
      end
      finish_test();

      start_test("priority");
      for (int s = 0; s < 4; s++) begin
         base = pick_addr(s, 16'h0011);
         apply_inputs(base, 8'hA5, 1'b1, 1'b0, base + 16'd2, 1'b0, base + 16'd1, 8'h3C, 1'b0);
         apply_inputs(16'h0, 8'h0, 1'b1, 1'b1, base + 16'd2, 1'b0, base + 16'd1, 8'h3C, 1'b0);
         apply_inputs(16'h0, 8'h0, 1'b1, 1'b1, base + 16'd2, 1'b0, 16'h0, 8'h0, 1'b1);
      end
      finish_test();

      start_test("read_return");
      for (int i = 0; i < 16; i++) begin
         apply_inputs(pick_addr(i % 4, lcg_next()), 8'h00, 1'b1, 1'b0,
                      16'h0, 1'b1, 16'h0, 8'h0, 1'b1);
      end
      for (int i = 0; i < 16; i++) begin
         apply_inputs(16'h0, 8'h00, 1'b1, 1'b1,
                      pick_addr(i % 4, lcg_next()), 1'b0, 16'h0, 8'h0, 1'b1);
      end
      finish_test();

      start_test("parallel");
      for (int i = 0; i < 16; i++) begin
         r = lcg_next();
         d = lcg_next();
         apply_inputs(pick_addr((i + 1) % 4, r), 8'h00, 1'b1, 1'b0,
                      16'h0, 1'b1, pick_addr(i % 4, d), r[7:0], 1'b0);
      end
      finish_test();

      $display("Tests: %0d passed, %0d failed, %0d mismatches",
               tests_passed, tests_failed, fail_count);
      if (fail_count == 0 && tests_failed == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* memory_router.f */
rtl/mem_map_pkg.sv
rtl/region_decoder.sv
rtl/slave_port_mux.sv
rtl/read_return_mux.sv
rtl/memory_router.sv
verif/tb_clock_gen.sv
verif/tb_memory_router.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_memory_router
FILELIST  ?= memory_router.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Test passed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
